//--- rtl/dcache_defines.svh
// cache geometry and address field positions
// shared by the package and the cache modules
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

`define DC_ADDR_W   16 // byte address
`define DC_WORD_W   16 // one data word
`define DC_TAG_W    5
`define DC_INDEX_W  7  // 128 blocks, direct mapped
`define DC_OFFS_W   3  // 8 words per block

`define DC_BLOCKS   128
`define DC_WORDS    8

// field positions in the address, bit 0 is always zero
`define DC_OFFS_LSB  1
`define DC_INDEX_LSB (`DC_OFFS_LSB + `DC_OFFS_W)
`define DC_TAG_LSB   (`DC_INDEX_LSB + `DC_INDEX_W)

`endif

//--- rtl/dcache_pkg.sv
// data cache types
// address fields, data word and fill engine states
`include "dcache_defines.svh"

package dcache_pkg;

	typedef logic [`DC_ADDR_W-1:0]  addr_t;  // byte address from the processor
	typedef logic [`DC_WORD_W-1:0]  word_t;  // data word
	typedef logic [`DC_TAG_W-1:0]   tag_t;   // upper address bits kept per block
	typedef logic [`DC_INDEX_W-1:0] index_t; // selects the block
	typedef logic [`DC_OFFS_W-1:0]  offs_t;  // word within the block

	// fill engine
	typedef enum logic [1:0] {
		IDLE,       // hits served, waiting for a miss
		WAIT_PAUSE, // miss seen, icache owns memory
		FILL,       // read requests out, words coming back
		WRITE_TAG   // block complete, set valid and tag
	} fill_state_t;

endpackage

//--- rtl/cache_tag_store.sv
// tag store of the data cache
// valid bit and tag per block, plus hit compare
`include "dcache_defines.svh"

module cache_tag_store (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_en,     // processor access this cycle
	input  logic              wrt_tag,    // fill done, mark block valid
	input  dcache_pkg::addr_t cache_addr, // addr_in or fill address, same tag and index
	output logic              hit
);
	import dcache_pkg::*;

	logic [`DC_BLOCKS-1:0] valid_q;        // one per block, cleared by reset
	tag_t                  tag_mem [`DC_BLOCKS];
	index_t                idx;
	tag_t                  tag;
	logic                  match;

	assign idx = cache_addr[`DC_TAG_LSB-1:`DC_INDEX_LSB];
	assign tag = cache_addr[`DC_ADDR_W-1:`DC_TAG_LSB];

	// valid bits are the only control state here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (wrt_tag) begin
			valid_q[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wrt_tag) begin
			tag_mem[idx] <= tag; // the only tag write, at end of fill
		end
	end

	assign match = valid_q[idx] && (tag_mem[idx] == tag);

	// no access means nothing to miss on
	// while the tag is being written, keep reporting a miss so the stall holds
	assign hit = !mem_en ? 1'b1 :
		wrt_tag ? 1'b0 : match;

endmodule

//--- rtl/cache_fill_fsm.sv
// fill engine of the data cache
// miss detection, pipelined block reads, fill counting
// and the write-through strobe
`include "dcache_defines.svh"

module cache_fill_fsm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_en,         // processor access this cycle
	input  logic              wrt_cmd,        // access is a write
	input  logic              hit,            // from tag store
	input  logic              ifsm_busy,      // icache holds memory, no fill start
	input  logic              mem_data_valid, // one per returned word
	input  dcache_pkg::addr_t addr_in,
	output logic              fsm_busy,       // stall to the pipeline
	output logic              read_req,       // one word read per strobe
	output logic              wrt_mem,        // write-through
	output logic              wrt_data,       // data array write enable
	output logic              wrt_tag,        // tag store write enable
	output dcache_pkg::addr_t miss_addr,      // address to memory
	output dcache_pkg::addr_t cache_addr      // address to both arrays
);
	import dcache_pkg::*;

	localparam offs_t OFFS_LAST = offs_t'(`DC_WORDS - 1);

	fill_state_t           state_q;
	fill_state_t           state_d;
	logic [`DC_OFFS_W:0]   req_cnt; // requests issued, msb set when all 8 are out
	offs_t                 ret_cnt; // words returned so far
	logic                  miss;
	logic                  write_hit;
	logic                  fill_wr;
	logic                  in_fill;
	logic [`DC_ADDR_W-`DC_INDEX_LSB-1:0] block; // tag and index of the access

	assign block   = addr_in[`DC_ADDR_W-1:`DC_INDEX_LSB];
	assign in_fill = (state_q == FILL);
	assign miss    = mem_en && !hit;

	// hits are only served from idle
	assign write_hit = (state_q == IDLE) && mem_en && wrt_cmd && hit;
	assign fill_wr   = in_fill && mem_data_valid; // returning word goes straight in

	// next state, fsm_busy comes out of the same decode
	always_comb begin
		state_d  = state_q;
		fsm_busy = 1'b1;
		case (state_q)
			IDLE: begin
				fsm_busy = miss; // rises in the miss cycle, no register
				if (miss) begin
					state_d = ifsm_busy ? WAIT_PAUSE : FILL;
				end
			end
			WAIT_PAUSE: begin
				if (!ifsm_busy) begin
					state_d = FILL;
				end
			end
			FILL: begin
				if (fill_wr && (ret_cnt == OFFS_LAST)) begin
					state_d = WRITE_TAG; // eighth word landed
				end
			end
			WRITE_TAG: begin
				state_d = IDLE; // held request hits next cycle
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
			req_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (!in_fill) begin
				req_cnt <= '0; // ready for the next fill
				ret_cnt <= '0;
			end else begin
				if (read_req) begin
					req_cnt <= req_cnt + (`DC_OFFS_W+1)'(1);
				end
				if (fill_wr) begin
					ret_cnt <= ret_cnt + offs_t'(1); // wraps to 0 after the last word
				end
			end
		end
	end

	// back to back requests, memory keeps up to latency reads in flight
	assign read_req = in_fill && !req_cnt[`DC_OFFS_W];

	assign wrt_tag  = (state_q == WRITE_TAG);
	assign wrt_data = write_hit || fill_wr;
	assign wrt_mem  = write_hit;

	// block aligned request address while filling, else the write-through address
	assign miss_addr = in_fill ?
		{block, req_cnt[`DC_OFFS_W-1:0], 1'b0} : addr_in;

	// arrays follow the return counter during the fill
	assign cache_addr = in_fill ? {block, ret_cnt, 1'b0} : addr_in;

endmodule

//--- rtl/cache_data_array.sv
// data array of the data cache
// 128 blocks of 8 words, write on wrt_data, combinational read
`include "dcache_defines.svh"

module cache_data_array (
	input  logic              clk,
	input  logic              wrt_data,   // fill word or write hit
	input  dcache_pkg::addr_t cache_addr,
	input  dcache_pkg::word_t mem_data,   // fill data or processor write data
	output dcache_pkg::word_t data_out
);
	import dcache_pkg::*;

	localparam int unsigned DEPTH = `DC_BLOCKS * `DC_WORDS;

	word_t  data_mem [DEPTH]; // contents only count where the valid bit is set
	index_t idx;
	offs_t  offs;
	logic [`DC_INDEX_W+`DC_OFFS_W-1:0] word_addr;

	assign idx  = cache_addr[`DC_TAG_LSB-1:`DC_INDEX_LSB];
	assign offs = cache_addr[`DC_INDEX_LSB-1:`DC_OFFS_LSB];

	// block major, the words of one block sit next to each other
	assign word_addr = {idx, offs};

	always_ff @(posedge clk) begin
		if (wrt_data) begin
			data_mem[word_addr] <= mem_data;
		end
	end

	// read hit data in the request cycle
	assign data_out = data_mem[word_addr];

endmodule

//--- rtl/dcache_top.sv
// direct mapped write-through data cache
// tag store, fill engine and data array
`include "dcache_defines.svh"

module dcache_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_en,         // processor uses memory this cycle
	input  logic              wrt_cmd,        // high for a store
	input  dcache_pkg::addr_t addr_in,        // held by the processor while stalled
	input  dcache_pkg::word_t mem_data,       // store data, or fill data when valid
	input  logic              mem_data_valid,
	input  logic              ifsm_busy,      // icache fill in progress
	output dcache_pkg::word_t data_out,
	output logic              fsm_busy,       // pipeline stall
	output logic              read_req,
	output logic              wrt_mem,
	output dcache_pkg::addr_t miss_addr
);
	import dcache_pkg::*;

	addr_t cache_addr; // addr_in outside a fill
	logic  hit;
	logic  wrt_tag;
	logic  wrt_data;

	// input side, hit check against the stored tag
	cache_tag_store i_tag_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_en     (mem_en),
		.wrt_tag    (wrt_tag),
		.cache_addr (cache_addr),
		.hit        (hit)
	);

	// miss handling and write-through
	cache_fill_fsm i_fill_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_en         (mem_en),
		.wrt_cmd        (wrt_cmd),
		.hit            (hit),
		.ifsm_busy      (ifsm_busy),
		.mem_data_valid (mem_data_valid),
		.addr_in        (addr_in),
		.fsm_busy       (fsm_busy),
		.read_req       (read_req),
		.wrt_mem        (wrt_mem),
		.wrt_data       (wrt_data),
		.wrt_tag        (wrt_tag),
		.miss_addr      (miss_addr),
		.cache_addr     (cache_addr)
	);

	// output side
	cache_data_array i_data_array (
		.clk        (clk),
		.wrt_data   (wrt_data),
		.cache_addr (cache_addr),
		.mem_data   (mem_data),
		.data_out   (data_out)
	);

endmodule

//--- sim/tb_clock_gen.sv
// clock source for the data cache testbench
// free running, 4 ns period
module tb_clock_gen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk; // half period
endmodule

//--- sim/mem_model.sv
// backing memory for the data cache testbench
// fixed latency pipelined reads, write-through capture
module mem_model #(
	parameter int LATENCY = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              read_req,  // one word per strobe
	input  logic              wrt_mem,   // write-through strobe
	input  dcache_pkg::addr_t addr,
	input  dcache_pkg::word_t wr_data,
	output dcache_pkg::word_t rd_data,
	output logic              rd_valid
);
	timeunit 1ns;
	timeprecision 100ps;
	import dcache_pkg::*;

	word_t              words [32768];    // one entry per 16-bit word
	logic [LATENCY-1:0] vld_pipe;         // requests in flight
	addr_t              addr_pipe [LATENCY];

	// word at byte address a starts as a ^ 5a5a
	initial begin
		for (int i = 0; i < 32768; i++) begin
			words[i] = {i[14:0], 1'b0} ^ 16'h5A5A;
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[LATENCY-2:0], read_req};
		end
		addr_pipe[0] <= addr;
		for (int i = 1; i < LATENCY; i++) begin
			addr_pipe[i] <= addr_pipe[i-1];
		end
		if (rst_n && wrt_mem) begin
			words[addr[15:1]] <= wr_data; // never stalls
		end
	end

	assign rd_valid = vld_pipe[LATENCY-1];
	assign rd_data  = words[addr_pipe[LATENCY-1][15:1]]; // contents at return time
endmodule

//--- sim/dcache_tb.sv
// table driven testbench for the data cache
// shadow memory and shadow tags give the expected values
module dcache_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import dcache_pkg::*;

	localparam int MEM_LATENCY = 4;
	localparam int NROWS       = 14;
	localparam int LIMIT       = NROWS * 60 + 5; // cycles before the run is stopped
	localparam logic [1:0] OP_RD  = 2'd0;
	localparam logic [1:0] OP_WR  = 2'd1;
	localparam logic [1:0] OP_OFF = 2'd2; // mem_en low

	typedef struct packed {
		logic [1:0] op;
		addr_t      addr;
		word_t      wdata;
		logic       rnd;   // write data from $urandom
		logic [3:0] pause; // cycles of ifsm_busy
		logic       miss;  // expected miss
	} row_t;

	logic  clk, rst_n, mem_en, wrt_cmd, ifsm_busy;
	logic  fsm_busy, read_req, wrt_mem, rd_valid;
	addr_t addr_in, miss_addr;
	word_t wdata, rd_data, mem_data, data_out;
	row_t  rows [NROWS];
	word_t shadow [32768];
	logic  sh_valid [128];
	tag_t  sh_tag [128];
	int    req_total = 0; // read_req strobes seen
	int    bad_total = 0; // strobes outside the requested block
	int    wr_total  = 0;
	int    row_errs, pass_cnt, fail_cnt, cycles;

	tb_clock_gen i_clk (.clk(clk));

	mem_model #(.LATENCY(MEM_LATENCY)) i_mem (
		.clk(clk), .rst_n(rst_n), .read_req(read_req), .wrt_mem(wrt_mem),
		.addr(miss_addr), .wr_data(mem_data), .rd_data(rd_data), .rd_valid(rd_valid)
	);

	assign mem_data = rd_valid ? rd_data : wdata; // fill words win the shared bus

	dcache_top i_dut (
		.clk(clk), .rst_n(rst_n), .mem_en(mem_en), .wrt_cmd(wrt_cmd),
		.addr_in(addr_in), .mem_data(mem_data), .mem_data_valid(rd_valid),
		.ifsm_busy(ifsm_busy), .data_out(data_out), .fsm_busy(fsm_busy),
		.read_req(read_req), .wrt_mem(wrt_mem), .miss_addr(miss_addr)
	);

	// strobe monitor, mid cycle where outputs are settled
	always @(negedge clk) begin
		if (rst_n && read_req) begin
			req_total <= req_total + 1;
			if (miss_addr[15:4] != addr_in[15:4] || miss_addr[0]) begin
				bad_total <= bad_total + 1;
			end
		end
		if (rst_n && wrt_mem) begin
			wr_total <= wr_total + 1;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic flag_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		row_errs = row_errs + 1;
	endtask

	task automatic run_row(input int r);
		row_t  rw;
		word_t data;
		logic  exp_miss;
		int    req_base, wr_base, bad_base, n;
		rw = rows[r];
		row_errs = 0;
		data = rw.rnd ? word_t'($urandom()) : rw.wdata;
		exp_miss = (rw.op != OP_OFF) &&
			(!sh_valid[rw.addr[10:4]] || sh_tag[rw.addr[10:4]] != rw.addr[15:11]);
		if (exp_miss != rw.miss) begin
			flag_error("table miss flag disagrees with the tag model");
		end
		req_base = req_total;
		wr_base  = wr_total;
		bad_base = bad_total;
		@(posedge clk);
		mem_en    <= (rw.op != OP_OFF);
		wrt_cmd   <= (rw.op != OP_RD); // disabled rows try a write too
		addr_in   <= rw.addr;
		wdata     <= data;
		ifsm_busy <= (rw.pause != 4'd0);
		@(negedge clk);
		if (rw.op == OP_OFF) begin
			repeat (3) begin
				if (fsm_busy || read_req || wrt_mem) begin
					flag_error("activity with mem_en low");
				end
				@(negedge clk);
			end
		end else begin
			if (fsm_busy != exp_miss) begin
				flag_error($sformatf("fsm_busy %b in request cycle", fsm_busy));
			end
			for (n = 1; n < int'(rw.pause); n++) begin
				@(negedge clk);
				if (!fsm_busy || read_req || req_total != req_base) begin
					flag_error("fill started while ifsm_busy was held");
				end
			end
			if (rw.pause != 4'd0) begin
				@(posedge clk);
				ifsm_busy <= 1'b0;
				@(negedge clk);
			end
			while (fsm_busy) @(negedge clk); // held request completes as a hit
			if (rw.op == OP_RD && data_out != shadow[rw.addr[15:1]]) begin
				flag_error($sformatf("data_out %h, expected %h", data_out,
					shadow[rw.addr[15:1]]));
			end
			if (rw.op == OP_WR && (!wrt_mem || miss_addr != rw.addr)) begin
				flag_error($sformatf("wrt_mem %b miss_addr %h on write", wrt_mem, miss_addr));
			end
		end
		@(posedge clk);
		mem_en    <= 1'b0;
		wrt_cmd   <= 1'b0;
		ifsm_busy <= 1'b0;
		@(negedge clk);
		if (req_total - req_base != (exp_miss ? 8 : 0) || bad_total != bad_base) begin
			flag_error($sformatf("%0d read_req strobes, %0d outside the block",
				req_total - req_base, bad_total - bad_base));
		end
		if (wr_total - wr_base != (rw.op == OP_WR ? 1 : 0)) begin
			flag_error($sformatf("%0d wrt_mem strobes", wr_total - wr_base));
		end
		if (rw.op == OP_WR) begin
			if (i_mem.words[rw.addr[15:1]] != data) begin
				flag_error("memory missed the write-through");
			end
			shadow[rw.addr[15:1]] = data;
		end
		if (rw.op != OP_OFF) begin
			sh_valid[rw.addr[10:4]] = 1'b1; // block resident after any access
			sh_tag[rw.addr[10:4]]   = rw.addr[15:11];
		end
		if (row_errs == 0) pass_cnt = pass_cnt + 1;
		else fail_cnt = fail_cnt + 1;
		$display("row %0d op %0d addr %h miss %b: %s", r, rw.op, rw.addr, exp_miss,
			row_errs == 0 ? "ok" : "FAILED");
	endtask

	initial begin
		rst_n     <= 1'b0;
		mem_en    <= 1'b0;
		wrt_cmd   <= 1'b0;
		ifsm_busy <= 1'b0;
		addr_in   <= '0;
		wdata     <= '0;
		pass_cnt = 0;
		fail_cnt = 0;
		cycles   = 0;
		void'($urandom(85));
		for (int i = 0; i < 32768; i++) shadow[i] = {i[14:0], 1'b0} ^ 16'h5A5A;
		for (int i = 0; i < 128; i++) sh_valid[i] = 1'b0;
		// op, address, write data, random, pause, miss
		rows[0]  = '{OP_RD,  16'h0124, 16'h0000, 1'b0, 4'd0, 1'b1}; // cold miss
		rows[1]  = '{OP_RD,  16'h012A, 16'h0000, 1'b0, 4'd0, 1'b0}; // hit, same block
		rows[2]  = '{OP_WR,  16'h0126, 16'h0000, 1'b1, 4'd0, 1'b0}; // write hit
		rows[3]  = '{OP_RD,  16'h0126, 16'h0000, 1'b0, 4'd0, 1'b0};
		rows[4]  = '{OP_WR,  16'h3450, 16'hBEEF, 1'b0, 4'd0, 1'b1}; // write miss
		rows[5]  = '{OP_RD,  16'h3450, 16'h0000, 1'b0, 4'd0, 1'b0};
		rows[6]  = '{OP_RD,  16'h345E, 16'h0000, 1'b0, 4'd0, 1'b0};
		rows[7]  = '{OP_RD,  16'h0924, 16'h0000, 1'b0, 4'd0, 1'b1}; // same index, new tag
		rows[8]  = '{OP_RD,  16'h0126, 16'h0000, 1'b0, 4'd0, 1'b1}; // refill, keeps write
		rows[9]  = '{OP_RD,  16'h5A80, 16'h0000, 1'b0, 4'd3, 1'b1}; // icache pause
		rows[10] = '{OP_OFF, 16'h0126, 16'h0000, 1'b1, 4'd0, 1'b0};
		rows[11] = '{OP_WR,  16'h5A82, 16'h0000, 1'b1, 4'd0, 1'b0};
		rows[12] = '{OP_WR,  16'h7F00, 16'h0000, 1'b1, 4'd2, 1'b1}; // paused write miss
		rows[13] = '{OP_RD,  16'h7F0E, 16'h0000, 1'b0, 4'd0, 1'b0};
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < NROWS; r++) run_row(r);
		$display("rows passed %0d, rows failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

//--- dcache_top.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_fill_fsm.sv
rtl/cache_data_array.sv
rtl/dcache_top.sv
sim/tb_clock_gen.sv
sim/mem_model.sv
sim/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module dcache_tb -f dcache_top.f -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
